/* Makefile */
VERILATOR ?= verilator
TOP       := mseEstimatorTb
FILELIST  := tb.f
FLAGS     := --binary --timing --assert -j 0
RUN_ARGS  := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)

/* rtl/log10Normalizer.sv */
`timescale 1ns/1ps

module log10Normalizer
(
    input  logic                        clk,
    input  logic                        reset,
    input  mseFormatPkg::sqSum_t        sumStage,
    output mseFormatPkg::normTerm_t     normStage
);

    logic [log10TablePkg::MANT_BITS-1:0]    mant;       // six bits from leading one down
    logic [4:0]                             expIdx;     // exponent + EXP_MAX

    // leading-one search over bits 47..20
    // bit p gives exponent p-33, nothing found gives -14
    always_comb
    begin
        mant   = sumStage.total[mseFormatPkg::SUM_SHIFT +: log10TablePkg::MANT_BITS];
        expIdx = 5'd0;
        for (int b = mseFormatPkg::SUM_SHIFT + log10TablePkg::MANT_BITS;
             b < mseFormatPkg::ACC_BITS; b++)
        begin
            if (sumStage.total[b])
            begin
                mant   = sumStage.total[b -: log10TablePkg::MANT_BITS];    // highest hit wins
                expIdx = 5'(b - (mseFormatPkg::SUM_SHIFT + log10TablePkg::MANT_BITS) + 1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            normStage.valid <= 1'b0;
        else
            normStage.valid <= sumStage.valid;
        if (sumStage.valid)
        begin
            // guard zero on top, room for the shifts below
            normStage.mant    <= {1'b0, mant,
                {(log10TablePkg::X_BITS - 1 - log10TablePkg::MANT_BITS){1'b0}}};
            normStage.logInit <= log10TablePkg::LOG2_STEP[expIdx];
            normStage.mseSum  <= sumStage.total[mseFormatPkg::SUM_SHIFT +:
                                                mseFormatPkg::SUM_BITS];
        end
    end

endmodule

/* rtl/log10ShiftAdd.sv */
`timescale 1ns/1ps

module log10ShiftAdd
(
    input  logic                        clk,
    input  logic                        reset,
    input  mseFormatPkg::normTerm_t     normStage,
    input  mseFormatPkg::mseConfig_t    cfg,
    output mseFormatPkg::mseResult_t    result
);

    logic [log10TablePkg::X_BITS-1:0]           xVal;       // driven toward 1.0
    logic [log10TablePkg::X_BITS-1:0]           xCand;      // x * (1 + 2^-(i+1))
    logic signed [log10TablePkg::LOG_BITS-1:0]  logAcc;     // Q4.7
    logic signed [log10TablePkg::LOG_BITS-1:0]  logSum;     // with offset, wraps

    // multiply x up by 1+2^-k while it stays below 1.0
    // each accepted step takes its log back out
    always_comb
    begin
        xVal   = normStage.mant;
        logAcc = normStage.logInit;
        xCand  = normStage.mant;
        for (int i = 0; i < log10TablePkg::NUM_ITERS; i++)
        begin
            xCand = xVal + (xVal >> (i + 1));
            if (!xCand[log10TablePkg::X_BITS-1])    // top bit set means x would pass 1.0
            begin
                xVal   = xCand;
                logAcc = logAcc - log10TablePkg::LOG_SCALE[i];
            end
        end
    end

    assign logSum = logAcc + cfg.log10MseOffset[log10TablePkg::LOG_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (reset)
            result <= '0;
        else
        begin
            result.valid <= normStage.valid;
            if (normStage.valid)
            begin
                result.mseSum      <= normStage.mseSum;
                result.log10MseSum <= logSum;
                result.log10Mse    <= {{(mseFormatPkg::OUT_BITS - log10TablePkg::LOG_BITS){
                                        logSum[log10TablePkg::LOG_BITS-1]}}, logSum};
            end
        end
    end

endmodule

/* rtl/log10TablePkg.sv */
package log10TablePkg;

    localparam int NUM_ITERS     = 6;                   // shift-add refinement steps
    localparam int LOG_FRAC_BITS = 7;
    localparam int LOG_BITS      = 4 + LOG_FRAC_BITS;   // Q4.7, signed
    localparam int MANT_BITS     = 6;                   // bits kept below leading one
    localparam int X_BITS        = 2 * NUM_ITERS + 1;   // guard bit + mantissa + shift room
    localparam int EXP_MAX       = 14;                  // exponent spans -14..14

    // log10(2^e) * 128 rounded, indexed by e + EXP_MAX
    localparam logic signed [LOG_BITS-1:0] LOG2_STEP [0:2*EXP_MAX] = '{
        -11'sd539,  // 2^-14, also used when nothing above bit 19
        -11'sd501,
        -11'sd462,
        -11'sd424,
        -11'sd385,
        -11'sd347,
        -11'sd308,
        -11'sd270,
        -11'sd231,
        -11'sd193,
        -11'sd154,
        -11'sd116,
        -11'sd77,
        -11'sd39,
        11'sd0,     // 2^0
        11'sd39,
        11'sd77,
        11'sd116,
        11'sd154,
        11'sd193,
        11'sd231,
        11'sd270,
        11'sd308,
        11'sd347,
        11'sd385,
        11'sd424,
        11'sd462,
        11'sd501,
        11'sd539    // 2^14
    };

    // log10(1 + 2^-(i+1)) * 128 rounded
    localparam logic [LOG_BITS-1:0] LOG_SCALE [0:NUM_ITERS-1] = '{
        11'd23, 11'd12, 11'd7, 11'd3, 11'd2, 11'd1
    };

endpackage

/* rtl/mseEstimator.sv */
`timescale 1ns/1ps

module mseEstimator
(
    input  logic                        clk,
    input  logic                        reset,
    input  mseFormatPkg::magSample_t    sample,         // valid is the sample strobe
    input  mseFormatPkg::mseConfig_t    cfg,            // static during a window
    input  logic                        startEstimate,  // falling edge arms a window
    output mseFormatPkg::mseResult_t    result
);

    mseFormatPkg::sqSum_t       sumStage;   // window total, 2 cycles after last sample
    mseFormatPkg::normTerm_t    normStage;  // mantissa and coarse log

    sqErrAccumulator accum0
    (
        .clk            (clk),
        .reset          (reset),
        .sample         (sample),
        .cfg            (cfg),
        .startEstimate  (startEstimate),
        .sumStage       (sumStage)
    );

    log10Normalizer norm0
    (
        .clk            (clk),
        .reset          (reset),
        .sumStage       (sumStage),
        .normStage      (normStage)
    );

    // result lands 4 cycles after the last sample edge
    log10ShiftAdd logCalc0
    (
        .clk            (clk),
        .reset          (reset),
        .normStage      (normStage),
        .cfg            (cfg),
        .result         (result)
    );

endmodule

/* rtl/mseFormatPkg.sv */
package mseFormatPkg;

    localparam int MAG_BITS  = 13;                      // Q0.13 magnitude
    localparam int MEAN_BITS = 16;                      // configured mean magnitude
    localparam int DIFF_BITS = 18;                      // mag*32 - mean*2, signed
    localparam int SQ_BITS   = 36;                      // squared difference
    localparam int ACC_BITS  = 48;                      // window total, 14 bits of headroom
    localparam int SUM_SHIFT = 14;                      // total >> 14 gives linear sum
    localparam int SUM_BITS  = ACC_BITS - SUM_SHIFT;    // 34
    localparam int OUT_BITS  = 16;                      // sign extended log output

    typedef struct packed {
        logic                   valid;                  // sample strobe
        logic [MAG_BITS-1:0]    mag;
    } magSample_t;

    typedef struct packed {
        logic [MEAN_BITS-1:0]       meanMag;
        logic [15:0]                avgLength;          // samples per window, 0 = off
        logic signed [OUT_BITS-1:0] log10MseOffset;     // log10(1/K/mean^2), Q4.7 in low bits
    } mseConfig_t;

    typedef struct packed {
        logic                   valid;                  // one cycle per window
        logic [ACC_BITS-1:0]    total;
    } sqSum_t;

    typedef struct packed {
        logic                                       valid;
        logic [log10TablePkg::X_BITS-1:0]           mant;       // 0.mmmmmm000000
        logic signed [log10TablePkg::LOG_BITS-1:0]  logInit;    // log10 of 2^exp
        logic [SUM_BITS-1:0]                        mseSum;     // rides along to output
    } normTerm_t;

    typedef struct packed {
        logic                                       valid;
        logic [SUM_BITS-1:0]                        mseSum;
        logic signed [log10TablePkg::LOG_BITS-1:0]  log10MseSum;    // Q4.7 incl offset
        logic signed [OUT_BITS-1:0]                 log10Mse;
    } mseResult_t;

endpackage

/* rtl/sqErrAccumulator.sv */
`timescale 1ns/1ps

module sqErrAccumulator
(
    input  logic                        clk,
    input  logic                        reset,
    input  mseFormatPkg::magSample_t    sample,
    input  mseFormatPkg::mseConfig_t    cfg,
    input  logic                        startEstimate,
    output mseFormatPkg::sqSum_t        sumStage
);

    typedef struct packed {
        logic                                       valid;  // in-window term
        logic                                       last;   // final term of window
        logic signed [mseFormatPkg::DIFF_BITS-1:0]  value;
    } diffTerm_t;

    logic                                       startPrev;      // startEstimate at last strobe
    logic [1:0]                                 startHist;      // {previous, current}
    logic                                       fallingEdge;
    logic [15:0]                                winCount;       // samples left in window
    logic                                       windowOpen;
    logic signed [mseFormatPkg::DIFF_BITS-1:0]  diffNext;
    diffTerm_t                                  diffReg;
    logic signed [mseFormatPkg::SQ_BITS-1:0]    diffWide;
    logic [mseFormatPkg::SQ_BITS-1:0]           sqTerm;
    logic [mseFormatPkg::ACC_BITS-1:0]          sqWide;
    logic [mseFormatPkg::ACC_BITS-1:0]          accum;          // running window sum
    logic                                       lastLanded;     // last term now in accum

    assign startHist   = {startPrev, startEstimate};
    assign fallingEdge = (startHist == 2'b10);
    assign windowOpen  = (winCount != 16'd0);

    // mag*32 - mean*2, mag below 4096 keeps it in range
    assign diffNext = {sample.mag, {(mseFormatPkg::DIFF_BITS - mseFormatPkg::MAG_BITS){1'b0}}}
                    - {1'b0, cfg.meanMag, 1'b0};

    assign diffWide = {{(mseFormatPkg::SQ_BITS - mseFormatPkg::DIFF_BITS){diffReg.value[
                        mseFormatPkg::DIFF_BITS-1]}}, diffReg.value};
    assign sqTerm   = diffWide * diffWide;                  // always positive
    assign sqWide   = {{(mseFormatPkg::ACC_BITS - mseFormatPkg::SQ_BITS){1'b0}}, sqTerm};

    // window control and difference register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            startPrev     <= 1'b0;
            winCount      <= 16'd0;
            diffReg.valid <= 1'b0;
            diffReg.last  <= 1'b0;
        end
        else
        begin
            diffReg.valid <= sample.valid & windowOpen;
            diffReg.last  <= sample.valid & (winCount == 16'd1);
            if (sample.valid)
            begin
                startPrev <= startEstimate;
                if (windowOpen)
                    winCount <= winCount - 16'd1;   // falling edges ignored here
                else if (fallingEdge)
                    winCount <= cfg.avgLength;      // zero keeps window closed
            end
        end
        if (sample.valid)
            diffReg.value <= diffNext;
    end

    // square and sum, hand total over once last term is in
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            accum          <= '0;
            lastLanded     <= 1'b0;
            sumStage.valid <= 1'b0;
        end
        else
        begin
            accum          <= (lastLanded ? '0 : accum) + (diffReg.valid ? sqWide : '0);
            lastLanded     <= diffReg.last;
            sumStage.valid <= lastLanded;
        end
        if (lastLanded)
            sumStage.total <= accum;
    end

endmodule

/* tb.f */
rtl/log10TablePkg.sv
rtl/mseFormatPkg.sv
rtl/sqErrAccumulator.sv
rtl/log10Normalizer.sv
rtl/log10ShiftAdd.sv
rtl/mseEstimator.sv
verification/mseEstimator_checker.sv
verification/mseEstimatorTb.sv

/* verification/mseEstimatorTb.sv */
`timescale 1ns/1ps

module mseEstimatorTb;

    localparam int          MAX_LEN     = 40;               // longest random window
    localparam int          NUM_RANDOM  = 12;
    localparam int          NUM_B2B     = 4;
    localparam int          NUM_WINDOWS = NUM_RANDOM + NUM_B2B + 2;
    localparam int          WATCHDOG    = NUM_WINDOWS * (MAX_LEN * 4 + 20) + 100;
    localparam logic [15:0] OFFSET      = 16'h1F2A;         // low 11 bits wrap the log

    typedef struct packed {
        logic [47:0]    total;                              // model window sum
        int             due;                                // cycle of result.valid
    } expect_t;

    logic                       clk = 1'b0;
    logic                       reset;
    mseFormatPkg::magSample_t   sample;
    mseFormatPkg::mseConfig_t   cfg;
    logic                       startEstimate;
    mseFormatPkg::mseResult_t   result;
    expect_t                    expQ [$];                   // one entry per armed window
    int                         cycle = 0;
    int                         errors = 0;
    int                         results = 0;
    logic [31:0]                rngState = 32'd99;

    mseEstimator dut0
    (
        .clk            (clk),
        .reset          (reset),
        .sample         (sample),
        .cfg            (cfg),
        .startEstimate  (startEstimate),
        .result         (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic int roundReal(input real v);
        return (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
    endfunction

    // leading one in 47..20, six mantissa bits, then six shift-add steps
    function automatic logic signed [10:0] expectLog(input logic [47:0] total,
                                                     input logic [15:0] offset);
        int             p;
        int             e;
        int             x;
        int             cand;
        int             logv;
        logic [10:0]    wrapped;
        p = -1;
        for (int b = 20; b < 48; b++)
            if (total[b])
                p = b;
        x = (p >= 0) ? int'((total >> (p - 5)) & 48'h3F) : int'((total >> 14) & 48'h3F);
        e = (p >= 0) ? p - 33 : -14;
        x = x << 6;                                         // 0.mmmmmm000000
        logv = roundReal(real'(e) * 128.0 * $log10(2.0));
        for (int i = 0; i < 6; i++)
        begin
            cand = x + (x >> (i + 1));
            if (cand < 4096)                                // still below 1.0
            begin
                x = cand;
                logv = logv - roundReal(128.0 * $log10(1.0 + 1.0 / real'(1 << (i + 1))));
            end
        end
        wrapped = 11'(logv + int'(offset[10:0]));
        return $signed(wrapped);
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] expVal,
                                  input logic [63:0] actVal);
        errors++;
        $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, expVal, actVal);
    endtask

    task automatic driveStrobe(input logic [12:0] mag, input logic start, input int maxGap);
        int gap;
        gap = (maxGap > 0) ? int'(nextRandom() % 32'(maxGap + 1)) : 0;
        for (int g = 0; g < gap; g++)
        begin
            @(posedge clk);
            #1;
            sample.valid  = 1'b0;
            sample.mag    = 13'(nextRandom());              // no strobe, not counted
            startEstimate = 1'(nextRandom());               // ignored off strobe
        end
        @(posedge clk);
        #1;
        sample.valid  = 1'b1;
        sample.mag    = mag;
        startEstimate = start;
    endtask

    // arm with 1 then 0 on strobes, then len samples, maybe an ignored edge inside
    task automatic runWindow(input int len, input logic [15:0] mean, input int fixedMag,
                             input int maxGap);
        int             mags [$];
        int             d;
        int             toggleAt;
        expect_t        item;
        item.total = '0;
        toggleAt = (len >= 2) ? int'(nextRandom() % 32'(len - 1)) : -1;
        for (int k = 0; k < len; k++)
        begin
            mags.push_back((fixedMag >= 0) ? fixedMag : int'(nextRandom() % 4096));
            d = mags[k] * 32 - int'(mean) * 2;
            item.total = item.total + 48'(longint'(d) * longint'(d));
        end
        driveStrobe(13'd0, 1'b1, maxGap);
        cfg.meanMag   = mean;                               // earlier window fully taken
        cfg.avgLength = 16'(len);
        driveStrobe(13'(nextRandom()), 1'b0, maxGap);       // falling edge arms here
        for (int k = 0; k < len; k++)
            driveStrobe(13'(mags[k]), 1'(k == toggleAt), maxGap);
        item.due = cycle + 5;                               // taking edge plus 4
        if (len > 0)
            expQ.push_back(item);
    endtask

    always @(negedge clk)
    begin : monitor
        expect_t            item;
        logic signed [10:0] expLog;
        if (!reset && result.valid)
        begin
            results++;
            if (expQ.size() == 0)
            begin
                errors++;
                $display("result.valid pulsed at cycle %0d with no window pending", cycle);
            end
            else
            begin
                item   = expQ.pop_front();
                expLog = expectLog(item.total, cfg.log10MseOffset);
                assert (cycle == item.due)
                else
                begin
                    errors++;
                    $display("result.valid came at cycle %0d, due %0d", cycle, item.due);
                end
                assert (result.mseSum == 34'(item.total >> 14))
                else reportMismatch("result.mseSum", 64'(item.total >> 14), 64'(result.mseSum));
                assert (result.log10MseSum == expLog)
                else reportMismatch("result.log10MseSum", 64'(expLog), 64'(result.log10MseSum));
                assert (result.log10Mse == 16'(expLog))
                else reportMismatch("result.log10Mse", 64'(16'(expLog)), 64'(result.log10Mse));
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout after %0d cycles, %0d results still pending", WATCHDOG, expQ.size());
        $display("** FAIL **");
        $finish;
    end

    initial
    begin : stimulus
        int checkerFails;
        reset              = 1'b1;
        sample             = '0;
        cfg                = '0;
        cfg.log10MseOffset = OFFSET;
        startEstimate      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (20)
        begin
            @(negedge clk);
            assert (result == '0)
            else reportMismatch("result", 64'd0, 64'(result));
        end
        runWindow(8, 16'd24000, 1500, 1);                   // zero error window
        runWindow(0, 16'd20000, -1, 1);                     // length zero opens nothing
        for (int w = 0; w < NUM_RANDOM; w++)
            runWindow(1 + int'(nextRandom() % MAX_LEN), 16'(nextRandom()), -1, 2);
        for (int w = 0; w < NUM_B2B; w++)
            runWindow(1 + int'(nextRandom() % 8), 16'(nextRandom()), -1, 0);
        @(posedge clk);
        #1;
        sample.valid = 1'b0;
        while (expQ.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);                         // catch stray results
        checkerFails = dut0.check0.pulseFails + dut0.check0.signFails + dut0.check0.resetFails;
        $display("%0d results, %0d value errors, %0d checker failures",
                 results, errors, checkerFails);
        if (errors == 0 && checkerFails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* verification/mseEstimator_checker.sv */
`timescale 1ns/1ps

module mseEstimatorChecker
(
    input  logic                        clk,
    input  logic                        reset,
    input  mseFormatPkg::sqSum_t        sumStage,
    input  mseFormatPkg::normTerm_t     normStage,
    input  mseFormatPkg::mseResult_t    result
);

    int     pulseFails = 0;     // per property, summed by the testbench
    int     signFails  = 0;
    int     resetFails = 0;
    logic   anyValid;

    assign anyValid = sumStage.valid | normStage.valid | result.valid;

    // results never come on adjacent cycles
    resultPulse: assert property (@(posedge clk) disable iff (reset)
        result.valid |=> !result.valid)
    else
    begin
        pulseFails++;
        $error("result.valid stayed high for more than one cycle");
    end

    signExtend: assert property (@(posedge clk) disable iff (reset)
        result.log10Mse == {{(mseFormatPkg::OUT_BITS - log10TablePkg::LOG_BITS){
            result.log10MseSum[log10TablePkg::LOG_BITS-1]}}, result.log10MseSum})
    else
    begin
        signFails++;
        $error("log10Mse is not the sign extension of log10MseSum");
    end

    // first reset edge clears the stages
    quietInReset: assert property (@(posedge clk) (reset && $past(reset)) |-> !anyValid)
    else
    begin
        resetFails++;
        $error("a stage valid was high during reset");
    end

endmodule

bind mseEstimator mseEstimatorChecker check0
(
    .clk        (clk),
    .reset      (reset),
    .sumStage   (sumStage),
    .normStage  (normStage),
    .result     (result)
);
